/* compile.f */
common/ace_pkg.sv
rtl/loader/byte_fifo.sv
rtl/loader/snapshot_decoder.sv
rtl/mem_arbiter.sv
rtl/main_ram.sv
rtl/ace_load_top.sv
tests/ace_load_checker.sv
tests/ace_load_tb.sv

/* tests/ace_tests.mem */
// One record per line: tag (1 hex), address (4 hex), data (2 hex)
// Tags: 1 new load at base, 2 stream byte, 3 expected after load, 4 read during load, F end
1010000
2000011
2000022
2000033
2000044
20000ED
2000000
3010011
3010344
100FE00
20000AA
20000BB
20000ED
2000000
20000CC
20000DD
300FEAA
300FFBB
3010011
3010122
1020000
20000ED
20000FF
20000ED
200007E
20000ED
2000000
30200ED
302FEED
302FF7E
4010233
400FFBB
4010344
F000000

/* tests/ace_load_tb.sv */
`timescale 1ns/100ps

module ace_load_tb import ace_pkg::*; ();

	localparam int CREDITS    = 4;
	localparam int WAIT_LIMIT = 2000;

	logic      clk_sys;
	logic      reset;
	load_ctl_t ctl;
	logic      stream_valid;
	byte_t     stream_data;
	logic      credit_return;
	mem_req_t  rd_req;
	logic      grant_rd;
	mem_rsp_t  rd_rsp;
	logic      busy;
	logic      done;
	byte_t     rd_exp;
	int        error_cnt;

	logic [27:0] recs [0:255]; // Tag, address, data
	integer      seed;
	int          sent_cnt;
	int          returned_cnt;

	ace_load_top #(.CREDITS(CREDITS), .RAM_WORDS(65536)) ace_load_top_i (.*);

	ace_load_checker #(.CREDITS(CREDITS)) ace_load_checker_i (.*);

	initial clk_sys = 1'b0;
	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		if (credit_return)
			returned_cnt++;
	end

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout at %0t ns while waiting for %s", $time, what);
		$display("sim failed");
		$finish;
	endtask

	task automatic send_byte(input byte_t b);
		int waited;
		int gap;
		waited = 0;
		while (sent_cnt - returned_cnt >= CREDITS && waited < WAIT_LIMIT) begin
			next_cycle();
			waited++;
		end
		if (sent_cnt - returned_cnt >= CREDITS)
			stop_on_timeout("a stream credit");
		gap = $unsigned($random(seed)) % 3; // Idle host cycles
		repeat (gap) next_cycle();
		stream_valid = 1'b1;
		stream_data  = b;
		sent_cnt++;
		next_cycle();
		stream_valid = 1'b0;
	endtask

	task automatic do_read(input addr_t addr, input byte_t exp);
		int waited;
		waited = 0;
		rd_req = '{valid: 1'b1, we: 1'b0, addr: addr, data: 8'h00};
		rd_exp = exp;
		@(posedge clk_sys);
		while (!grant_rd && waited < WAIT_LIMIT) begin
			@(posedge clk_sys);
			waited++;
		end
		if (!grant_rd)
			stop_on_timeout("a read grant");
		#2;
		rd_req = '0;
	endtask

	task automatic wait_done();
		int waited;
		waited = 0;
		@(posedge clk_sys);
		while (!done && waited < WAIT_LIMIT) begin
			@(posedge clk_sys);
			waited++;
		end
		if (!done)
			stop_on_timeout("done");
	endtask

	task automatic run_test(input int num, input int first, input int last);
		int    waited;
		addr_t base;
		base = recs[first][23:8];
		ctl  = '{start: 1'b1, base: base};
		next_cycle();
		ctl = '0;
		fork
			for (int i = first + 1; i < last; i++)
				if (recs[i][27:24] == 4'h2)
					send_byte(recs[i][7:0]);
			for (int i = first + 1; i < last; i++)
				if (recs[i][27:24] == 4'h4)
					do_read(recs[i][23:8], recs[i][7:0]);
			wait_done();
		join
		next_cycle();
		waited = 0;
		while (returned_cnt != sent_cnt && waited < WAIT_LIMIT) begin
			next_cycle();
			waited++;
		end
		if (returned_cnt != sent_cnt)
			stop_on_timeout("credits for all sent bytes");
		for (int i = first + 1; i < last; i++)
			if (recs[i][27:24] == 4'h3)
				do_read(recs[i][23:8], recs[i][7:0]);
		next_cycle(); // Last response reaches the checker
		ace_load_checker_i.end_test(num, base);
	endtask

	initial begin
		int idx;
		int last;
		int num;
		seed         = 32'h9dd5;
		reset        = 1'b1;
		ctl          = '0;
		stream_valid = 1'b0;
		stream_data  = '0;
		rd_req       = '0;
		rd_exp       = '0;
		sent_cnt     = 0;
		returned_cnt = 0;
		$readmemh("tests/ace_tests.mem", recs);
		repeat (10) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		next_cycle();
		idx = 0;
		num = 0;
		while (recs[idx][27:24] === 4'h1) begin
			last = idx + 1;
			while (recs[last][27:24] inside {4'h2, 4'h3, 4'h4})
				last++;
			num++;
			run_test(num, idx, last);
			idx = last;
		end
		ace_load_checker_i.print_counts();
		if (error_cnt == 0 && num > 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* tests/ace_load_checker.sv */
`timescale 1ns/100ps

module ace_load_checker import ace_pkg::*; #(
	parameter int CREDITS = 4
) (
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     stream_valid,
	input  logic     credit_return,
	input  mem_req_t rd_req,
	input  logic     grant_rd,
	input  byte_t    rd_exp,
	input  mem_rsp_t rd_rsp,
	input  logic     busy,
	input  logic     done,
	output int       error_cnt
);

	int    outstanding;
	int    reads_cnt;
	int    tests_cnt;
	int    tests_failed;
	int    errors_before;
	logic  pend;
	addr_t pend_addr;
	byte_t pend_exp;

	always @(posedge clk_sys) begin
		if (reset) begin
			outstanding = 0;
			pend        = 1'b0;
		end else begin
			outstanding = outstanding + int'(stream_valid) - int'(credit_return);
			if (outstanding > CREDITS) begin
				$display("host holds %0d unreturned bytes at %0t ns, more than its %0d credits",
					outstanding, $time, CREDITS);
				error_cnt++;
			end else if (outstanding < 0) begin
				$display("credit returned at %0t ns for a byte that was never sent", $time);
				error_cnt++;
			end
			if (pend) begin // Response is due one cycle after the grant
				reads_cnt++;
				if (!rd_rsp.valid) begin
					$display("read of address %h got no response at %0t ns", pend_addr, $time);
					error_cnt++;
				end else if (rd_rsp.data !== pend_exp) begin
					$display("error at %0t ns: rd_rsp 8'h%h, expected 8'h%h (address %h)",
						$time, rd_rsp.data, pend_exp, pend_addr);
					error_cnt++;
				end
			end else if (rd_rsp.valid) begin
				$display("read response at %0t ns without a granted read", $time);
				error_cnt++;
			end
			if (done && busy) begin
				$display("busy still high when done pulsed at %0t ns", $time);
				error_cnt++;
			end
			pend      = grant_rd;
			pend_addr = rd_req.addr;
			pend_exp  = rd_exp;
		end
	end

	task automatic end_test(input int num, input addr_t base);
		tests_cnt++;
		if (error_cnt == errors_before) begin
			$display("test %0d (base %h): ok", num, base);
		end else begin
			tests_failed++;
			$display("test %0d (base %h): %0d errors", num, base, error_cnt - errors_before);
		end
		errors_before = error_cnt;
	endtask

	task automatic print_counts();
		$display("tests %0d, with errors %0d, reads checked %0d, errors %0d",
			tests_cnt, tests_failed, reads_cnt, error_cnt);
	endtask

endmodule

/* rtl/ace_load_top.sv */
`timescale 1ns/100ps

module ace_load_top import ace_pkg::*; #(
	parameter int CREDITS   = 4,
	parameter int RAM_WORDS = 65536
) (
	input  logic      clk_sys,
	input  logic      reset,
	input  load_ctl_t ctl,
	input  logic      stream_valid,
	input  byte_t     stream_data,
	output logic      credit_return,
	input  mem_req_t  rd_req,
	output logic      grant_rd,
	output mem_rsp_t  rd_rsp,
	output logic      busy,
	output logic      done
);

	logic     fifo_empty;
	byte_t    fifo_data;
	logic     pop;
	mem_req_t load_req;
	logic     grant_load;
	mem_req_t ram_req;

	byte_fifo #(
		.CREDITS(CREDITS)
	) byte_fifo_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.in_valid(stream_valid),
		.in_data (stream_data),
		.pop     (pop),
		.empty   (fifo_empty),
		.out_data(fifo_data)
	);

	snapshot_decoder #(
		.CREDITS(CREDITS)
	) snapshot_decoder_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.ctl          (ctl),
		.fifo_empty   (fifo_empty),
		.fifo_data    (fifo_data),
		.pop          (pop),
		.credit_return(credit_return),
		.req          (load_req),
		.grant_load   (grant_load),
		.busy         (busy),
		.done         (done)
	);

	mem_arbiter mem_arbiter_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.load_req  (load_req),
		.rd_req    (rd_req),
		.grant_load(grant_load),
		.grant_rd  (grant_rd),
		.ram_req   (ram_req)
	);

	// Only the read port issues reads, so every response is its own
	main_ram #(
		.RAM_WORDS(RAM_WORDS)
	) main_ram_i (
		.clk_sys(clk_sys),
		.req    (ram_req),
		.rsp    (rd_rsp)
	);

endmodule

/* rtl/main_ram.sv */
`timescale 1ns/100ps

module main_ram import ace_pkg::*; #(
	parameter int RAM_WORDS = 65536
) (
	input  logic     clk_sys,
	input  mem_req_t req,
	output mem_rsp_t rsp
);

	localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

	byte_t mem [RAM_WORDS];

	always_ff @(posedge clk_sys) begin
		if (req.valid && req.we)
			mem[req.addr[AW-1:0]] <= req.data;
		rsp.valid <= req.valid && !req.we; // Writes give no response
		rsp.data  <= mem[req.addr[AW-1:0]];
	end

endmodule

/* rtl/mem_arbiter.sv */
`timescale 1ns/100ps

module mem_arbiter import ace_pkg::*; (
	input  logic     clk_sys,
	input  logic     reset,
	input  mem_req_t load_req,
	input  mem_req_t rd_req,
	output logic     grant_load,
	output logic     grant_rd,
	output mem_req_t ram_req
);

	logic last_rd; // Read port won the last contested or uncontested cycle

	assign grant_load = load_req.valid && (!rd_req.valid || last_rd);
	assign grant_rd   = rd_req.valid && !grant_load;

	always_comb begin
		ram_req = '0;
		if (grant_load)
			ram_req = load_req;
		else if (grant_rd)
			ram_req = rd_req;
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			last_rd <= 1'b1; // Loader goes first
		else if (grant_load || grant_rd)
			last_rd <= grant_rd;
	end

	// Two cycles of contention must split between the peers
	assert property (@(posedge clk_sys) disable iff (reset)
		(load_req.valid && rd_req.valid) ##1 (load_req.valid && rd_req.valid)
		|-> grant_load != $past(grant_load))
		else $error("mem_arbiter: same requester won twice under contention");

	// A held read must not starve behind the loader
	assert property (@(posedge clk_sys) disable iff (reset)
		rd_req.valid && !grant_rd |=> grant_rd || !rd_req.valid)
		else $error("mem_arbiter: read request waited more than one cycle");

endmodule

/* rtl/loader/snapshot_decoder.sv */
`timescale 1ns/100ps

module snapshot_decoder import ace_pkg::*; #(
	parameter int CREDITS = 4
) (
	input  logic      clk_sys,
	input  logic      reset,
	input  load_ctl_t ctl,
	input  logic      fifo_empty,
	input  byte_t     fifo_data,
	output logic      pop,
	output logic      credit_return,
	output mem_req_t  req,
	input  logic      grant_load,
	output logic      busy,
	output logic      done
);

	typedef enum logic [1:0] {
		ST_LITERAL,
		ST_COUNT,
		ST_VALUE,
		ST_ENDED
	} state_t;

	state_t state;
	logic   req_valid;
	addr_t  addr;
	byte_t  data;
	byte_t  run_cnt; // Writes left, the pending one included
	logic   last_write;
	logic   write_pending;

	assign last_write = (run_cnt == 8'd1);

	// The last write of a run may be granted in the same cycle as the next pop
	assign write_pending = req_valid && !(grant_load && last_write);

	assign pop           = !fifo_empty && !write_pending && !ctl.start;
	assign credit_return = pop;

	assign req = '{valid: req_valid, we: 1'b1, addr: addr, data: data};

	always_ff @(posedge clk_sys) begin
		done <= 1'b0;
		if (reset) begin
			state     <= ST_ENDED; // Stray bytes before a load are discarded
			req_valid <= 1'b0;
			run_cnt   <= '0;
			busy      <= 1'b0;
		end else if (ctl.start) begin
			state     <= ST_LITERAL;
			req_valid <= 1'b0;
			run_cnt   <= '0;
			addr      <= ctl.base;
			busy      <= 1'b1;
		end else begin
			if (req_valid && grant_load) begin
				addr    <= addr + 16'd1;
				run_cnt <= run_cnt - 8'd1;
				if (last_write)
					req_valid <= 1'b0;
			end

			if (state == ST_ENDED && busy) begin
				busy <= 1'b0;
				done <= 1'b1;
			end

			if (pop) begin
				case (state)
					ST_LITERAL: begin
						if (fifo_data == ESCAPE_BYTE) begin
							state <= ST_COUNT;
						end else begin
							req_valid <= 1'b1;
							data      <= fifo_data;
							run_cnt   <= 8'd1;
						end
					end
					ST_COUNT: begin
						if (fifo_data == END_COUNT) begin
							state <= ST_ENDED;
						end else begin
							run_cnt <= fifo_data;
							state   <= ST_VALUE;
						end
					end
					ST_VALUE: begin
						req_valid <= 1'b1; // Run length already in run_cnt
						data      <= fifo_data;
						state     <= ST_LITERAL;
					end
					default: begin
						state <= ST_ENDED; // Trailing bytes only return credits
					end
				endcase
			end
		end
	end

	// Credit scheme needs at least one buffered byte
	initial begin
		assert (CREDITS > 0)
			else $error("snapshot_decoder: CREDITS must be at least 1");
	end

	// Arbiter relies on a held request
	assert property (@(posedge clk_sys) disable iff (reset)
		req.valid && !grant_load && !ctl.start |=> $stable(req))
		else $error("snapshot_decoder: write request changed before grant");

endmodule

/* rtl/loader/byte_fifo.sv */
`timescale 1ns/100ps

module byte_fifo import ace_pkg::*; #(
	parameter int CREDITS = 4
) (
	input  logic  clk_sys,
	input  logic  reset,
	input  logic  in_valid,
	input  byte_t in_data,
	input  logic  pop,
	output logic  empty,
	output byte_t out_data
);

	localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
	localparam int CNT_W = $clog2(CREDITS + 1);

	byte_t            mem [CREDITS];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign empty    = (count == '0);
	assign out_data = mem[rd_ptr]; // Head byte, registered storage only

	always_ff @(posedge clk_sys) begin
		if (in_valid)
			mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (in_valid)
				wr_ptr <= (wr_ptr == PTR_W'(CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(in_valid) - CNT_W'(pop);
		end
	end

	// Host must respect its credits
	assert property (@(posedge clk_sys) disable iff (reset)
		in_valid |-> count < CNT_W'(CREDITS))
		else $error("byte_fifo: byte written while full");

	assert property (@(posedge clk_sys) disable iff (reset)
		pop |-> !empty)
		else $error("byte_fifo: pop while empty");

endmodule

/* common/ace_pkg.sv */
package ace_pkg;

	typedef logic [15:0] addr_t;
	typedef logic [7:0]  byte_t;

	// Stream escape, followed by a count and a value
	localparam byte_t ESCAPE_BYTE = 8'hED;

	// Count of zero after an escape ends the image
	localparam byte_t END_COUNT = 8'h00;

	// One RAM access, a read when we is low
	typedef struct packed {
		logic  valid;
		logic  we;
		addr_t addr;
		byte_t data;
	} mem_req_t;

	// Read data, valid one cycle after the grant
	typedef struct packed {
		logic  valid;
		byte_t data;
	} mem_rsp_t;

	typedef struct packed {
		logic  start; // Single-cycle pulse
		addr_t base;  // First write address of the image
	} load_ctl_t;

endpackage
